/* gfx_defines.svh */
`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// screen
`define GFX_SCREEN_W 160
`define GFX_SCREEN_H 120

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone
`define GFX_WB_ADR_W 3            // word address.
`define GFX_WB_DAT_W 16

// register word addresses.
`define GFX_REG_CTRL    3'd0
`define GFX_REG_STATUS  3'd1
`define GFX_REG_P0      3'd2
`define GFX_REG_P1      3'd3
`define GFX_REG_COLOUR  3'd4
`define GFX_REG_PIX_ADR 3'd5
`define GFX_REG_PIX_DAT 3'd6

`endif

/* gfx_pkg.sv */
package gfx_pkg;

    typedef logic [7:0] x_coord_t;
    typedef logic [6:0] y_coord_t;
    typedef logic [2:0] colour_t;

    // one pixel per cycle into the frame buffer.
    typedef struct packed {
        logic     plot;
        x_coord_t x;
        y_coord_t y;
        colour_t  colour;
    } pixel_t;

    typedef struct packed {
        x_coord_t x0;
        y_coord_t y0;
        x_coord_t x1;
        y_coord_t y1;
        colour_t  colour;
    } line_cmd_t;

    typedef enum logic [1:0] {LINE_IDLE, LINE_DRAW, LINE_FINISH} line_state_t;
    typedef enum logic {CLEAR_IDLE, CLEAR_SWEEP} clear_state_t;

endpackage

/* wb_pkg.sv */
`include "gfx_defines.svh"

package wb_pkg;

    typedef logic [`GFX_WB_ADR_W-1:0] wb_adr_t;
    typedef logic [`GFX_WB_DAT_W-1:0] wb_dat_t;

    // host to slave.
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat_w;
    } wb_req_t;

    // slave to host.
    typedef struct packed {
        logic    ack;
        wb_dat_t dat_r;
    } wb_rsp_t;

endpackage

/* gfx_wb_regs.sv */
`timescale 1ns/100ps
`include "gfx_defines.svh"

module gfx_wb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  wb_pkg::wb_req_t    wb_req,
    output wb_pkg::wb_rsp_t    wb_rsp,
    output gfx_pkg::line_cmd_t line_cmd,
    output logic               line_start,
    output logic               clear_start,
    input  logic               line_done,
    input  logic               clear_done,
    output gfx_pkg::x_coord_t  rd_x,
    output gfx_pkg::y_coord_t  rd_y,
    input  gfx_pkg::colour_t   rd_colour
);

    logic              ack_q;
    logic              acked;          // strobe already answered.
    logic              pix_wait;       // frame buffer read in flight.
    wb_pkg::wb_dat_t   dat_q;
    wb_pkg::wb_dat_t   rd_mux;
    logic              req_new;
    logic              wr_en;
    logic              busy;
    logic              done;
    gfx_pkg::x_coord_t p0_x;
    gfx_pkg::y_coord_t p0_y;
    gfx_pkg::x_coord_t p1_x;
    gfx_pkg::y_coord_t p1_y;
    gfx_pkg::colour_t  colour;
    gfx_pkg::x_coord_t pa_x;
    gfx_pkg::y_coord_t pa_y;

    assign req_new = wb_req.cyc && wb_req.stb && !ack_q && !pix_wait && !acked;
    assign wr_en   = req_new && wb_req.we;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            acked    <= 1'b0;
            pix_wait <= 1'b0;
        end else begin
            ack_q    <= 1'b0;
            pix_wait <= 1'b0;
            acked    <= (ack_q || acked) && wb_req.cyc && wb_req.stb;
            if (pix_wait) begin
                ack_q <= 1'b1;
            end else if (req_new) begin
                if (!wb_req.we && wb_req.adr == `GFX_REG_PIX_DAT)
                    pix_wait <= 1'b1;          // one extra cycle for the memory.
                else
                    ack_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_wait)
            dat_q <= {{(`GFX_WB_DAT_W-3){1'b0}}, rd_colour};
        else if (req_new)
            dat_q <= rd_mux;
    end

    always_comb begin
        rd_mux = '0;
        case (wb_req.adr)
            `GFX_REG_STATUS:  rd_mux[1:0]  = {done, busy};
            `GFX_REG_P0:      rd_mux[14:0] = {p0_y, p0_x};
            `GFX_REG_P1:      rd_mux[14:0] = {p1_y, p1_x};
            `GFX_REG_COLOUR:  rd_mux[2:0]  = colour;
            `GFX_REG_PIX_ADR: rd_mux[14:0] = {pa_y, pa_x};
            default:          rd_mux       = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command registers
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wb_req.adr)
                `GFX_REG_P0: begin
                    p0_x <= wb_req.dat_w[7:0];
                    p0_y <= wb_req.dat_w[14:8];
                end
                `GFX_REG_P1: begin
                    p1_x <= wb_req.dat_w[7:0];
                    p1_y <= wb_req.dat_w[14:8];
                end
                `GFX_REG_COLOUR: colour <= wb_req.dat_w[2:0];
                `GFX_REG_PIX_ADR: begin
                    pa_x <= wb_req.dat_w[7:0];
                    pa_y <= wb_req.dat_w[14:8];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            line_start  <= 1'b0;
            clear_start <= 1'b0;
        end else begin
            line_start  <= 1'b0;
            clear_start <= 1'b0;
            if (line_done || clear_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (wr_en && wb_req.adr == `GFX_REG_CTRL && !busy) begin
                if (wb_req.dat_w[0]) begin
                    line_start <= 1'b1;
                    busy       <= 1'b1;
                    done       <= 1'b0;
                end else if (wb_req.dat_w[1]) begin
                    clear_start <= 1'b1;
                    busy        <= 1'b1;
                    done        <= 1'b0;
                end
            end
        end
    end

    assign line_cmd.x0     = p0_x;
    assign line_cmd.y0     = p0_y;
    assign line_cmd.x1     = p1_x;
    assign line_cmd.y1     = p1_y;
    assign line_cmd.colour = colour;

    assign rd_x = pa_x;
    assign rd_y = pa_y;

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_q;

    // classic cycle, one ack per strobe.
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack);

endmodule

/* drawline.sv */
`timescale 1ns/100ps
`include "gfx_defines.svh"

module drawline (
    input  logic               clk,
    input  logic               rst_n,
    input  gfx_pkg::line_cmd_t cmd,
    input  logic               start,
    output logic               done,
    output gfx_pkg::pixel_t    pixel
);

    gfx_pkg::line_state_t state;
    gfx_pkg::line_cmd_t   cmd_q;
    gfx_pkg::x_coord_t    cur_x;
    gfx_pkg::y_coord_t    cur_y;
    gfx_pkg::x_coord_t    x_nxt;
    gfx_pkg::y_coord_t    y_nxt;
    logic                 x_neg;
    logic                 y_neg;
    logic [7:0]           abs_dx;
    logic [6:0]           abs_dy;
    logic signed [11:0]   dx;
    logic signed [11:0]   dy;          // kept negative.
    logic signed [11:0]   err;
    logic signed [11:0]   e2;
    logic signed [11:0]   err_nxt;
    logic                 step_x;
    logic                 step_y;
    logic                 at_end;
    logic                 plot_q;

    function automatic logic on_screen(input gfx_pkg::x_coord_t x, input gfx_pkg::y_coord_t y);
        return (x < 8'(`GFX_SCREEN_W)) && (y < 7'(`GFX_SCREEN_H));
    endfunction

    assign abs_dx = (cmd.x1 < cmd.x0) ? cmd.x0 - cmd.x1 : cmd.x1 - cmd.x0;
    assign abs_dy = (cmd.y1 < cmd.y0) ? cmd.y0 - cmd.y1 : cmd.y1 - cmd.y0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bresenham step
    assign e2     = err <<< 1;
    assign step_x = (e2 >= dy);
    assign step_y = (e2 <= dx);
    assign at_end = (cur_x == cmd_q.x1) && (cur_y == cmd_q.y1);

    always_comb begin
        err_nxt = err;
        if (step_x)
            err_nxt = err_nxt + dy;
        if (step_y)
            err_nxt = err_nxt + dx;
    end

    assign x_nxt = !step_x ? cur_x : (x_neg ? cur_x - 8'd1 : cur_x + 8'd1);
    assign y_nxt = !step_y ? cur_y : (y_neg ? cur_y - 7'd1 : cur_y + 7'd1);

    always_ff @(posedge clk) begin
        if (state == gfx_pkg::LINE_IDLE && start) begin
            cmd_q <= cmd;
            cur_x <= cmd.x0;
            cur_y <= cmd.y0;
            x_neg <= cmd.x1 < cmd.x0;
            y_neg <= cmd.y1 < cmd.y0;
            dx    <= $signed({4'b0000, abs_dx});
            dy    <= -$signed({5'b00000, abs_dy});
            err   <= $signed({4'b0000, abs_dx}) - $signed({5'b00000, abs_dy});
        end else if (state == gfx_pkg::LINE_DRAW && !at_end) begin
            cur_x <= x_nxt;
            cur_y <= y_nxt;
            err   <= err_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= gfx_pkg::LINE_IDLE;
            plot_q <= 1'b0;
        end else begin
            case (state)
                gfx_pkg::LINE_IDLE: begin
                    if (start) begin
                        state  <= gfx_pkg::LINE_DRAW;
                        plot_q <= on_screen(cmd.x0, cmd.y0);
                    end
                end
                gfx_pkg::LINE_DRAW: begin
                    if (at_end) begin
                        state  <= gfx_pkg::LINE_FINISH;
                        plot_q <= 1'b0;
                    end else begin
                        plot_q <= on_screen(x_nxt, y_nxt);   // step advances regardless.
                    end
                end
                gfx_pkg::LINE_FINISH: state <= gfx_pkg::LINE_IDLE;
                default:              state <= gfx_pkg::LINE_IDLE;
            endcase
        end
    end

    assign done = (state == gfx_pkg::LINE_FINISH);

    assign pixel.plot   = plot_q;
    assign pixel.x      = cur_x;
    assign pixel.y      = cur_y;
    assign pixel.colour = cmd_q.colour;

    a_idle_no_plot: assert property (@(posedge clk) disable iff (!rst_n)
        (state == gfx_pkg::LINE_IDLE) |-> !pixel.plot);

endmodule

/* clear_screen.sv */
`timescale 1ns/100ps
`include "gfx_defines.svh"

module clear_screen (
    input  logic              clk,
    input  logic              rst_n,
    input  gfx_pkg::colour_t  colour,
    input  logic              start,
    output logic              done,
    output gfx_pkg::pixel_t   pixel
);

    gfx_pkg::clear_state_t state;
    gfx_pkg::x_coord_t     cnt_x;
    gfx_pkg::y_coord_t     cnt_y;
    gfx_pkg::colour_t      colour_q;
    logic                  row_end;
    logic                  last_pix;
    logic                  done_q;

    assign row_end  = (cnt_x == 8'(`GFX_SCREEN_W - 1));
    assign last_pix = row_end && (cnt_y == 7'(`GFX_SCREEN_H - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= gfx_pkg::CLEAR_IDLE;
            cnt_x  <= '0;
            cnt_y  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                gfx_pkg::CLEAR_IDLE: begin
                    if (start) begin
                        state <= gfx_pkg::CLEAR_SWEEP;
                        cnt_x <= '0;
                        cnt_y <= '0;
                    end
                end
                gfx_pkg::CLEAR_SWEEP: begin
                    if (last_pix) begin
                        state  <= gfx_pkg::CLEAR_IDLE;
                        done_q <= 1'b1;            // cycle after (159, 119).
                    end else if (row_end) begin
                        cnt_x <= '0;
                        cnt_y <= cnt_y + 7'd1;
                    end else begin
                        cnt_x <= cnt_x + 8'd1;
                    end
                end
                default: state <= gfx_pkg::CLEAR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == gfx_pkg::CLEAR_IDLE && start)
            colour_q <= colour;
    end

    assign done = done_q;

    assign pixel.plot   = (state == gfx_pkg::CLEAR_SWEEP);
    assign pixel.x      = cnt_x;
    assign pixel.y      = cnt_y;
    assign pixel.colour = colour_q;

endmodule

/* framebuffer.sv */
`timescale 1ns/100ps
`include "gfx_defines.svh"

module framebuffer (
    input  logic              clk,
    input  gfx_pkg::pixel_t   line_pix,
    input  gfx_pkg::pixel_t   clear_pix,
    input  gfx_pkg::x_coord_t rd_x,
    input  gfx_pkg::y_coord_t rd_y,
    output gfx_pkg::colour_t  rd_colour
);

    localparam int DEPTH = `GFX_SCREEN_W * `GFX_SCREEN_H;

    gfx_pkg::colour_t mem [DEPTH];
    gfx_pkg::pixel_t  wr_pix;
    logic [14:0]      wr_adr;
    logic [14:0]      rd_adr;

    // row major, y * width + x.
    function automatic logic [14:0] pix_adr(input gfx_pkg::x_coord_t x,
                                            input gfx_pkg::y_coord_t y);
        return 15'(y) * 15'(`GFX_SCREEN_W) + 15'(x);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    assign wr_pix = line_pix.plot ? line_pix : clear_pix;
    assign wr_adr = pix_adr(wr_pix.x, wr_pix.y);

    always_ff @(posedge clk) begin
        if (wr_pix.plot)
            mem[wr_adr] <= wr_pix.colour;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port
    assign rd_adr = pix_adr(rd_x, rd_y);

    always_ff @(posedge clk) begin
        rd_colour <= mem[rd_adr];           // one cycle latency.
    end

    // only one engine may run at a time.
    a_one_writer: assert property (@(posedge clk)
        line_pix.plot |-> !clear_pix.plot);

endmodule

/* gfx_top.sv */
`timescale 1ns/100ps

module gfx_top (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t wb_req,
    output wb_pkg::wb_rsp_t wb_rsp
);

    gfx_pkg::line_cmd_t line_cmd;
    logic               line_start;
    logic               clear_start;
    logic               line_done;
    logic               clear_done;
    gfx_pkg::pixel_t    line_pix;
    gfx_pkg::pixel_t    clear_pix;
    gfx_pkg::x_coord_t  rd_x;
    gfx_pkg::y_coord_t  rd_y;
    gfx_pkg::colour_t   rd_colour;

    gfx_wb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .line_cmd    (line_cmd),
        .line_start  (line_start),
        .clear_start (clear_start),
        .line_done   (line_done),
        .clear_done  (clear_done),
        .rd_x        (rd_x),
        .rd_y        (rd_y),
        .rd_colour   (rd_colour)
    );

    drawline u_line (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (line_cmd),
        .start (line_start),
        .done  (line_done),
        .pixel (line_pix)
    );

    clear_screen u_clear (
        .clk    (clk),
        .rst_n  (rst_n),
        .colour (line_cmd.colour),        // shares the COLOUR register.
        .start  (clear_start),
        .done   (clear_done),
        .pixel  (clear_pix)
    );

    framebuffer u_fb (
        .clk       (clk),
        .line_pix  (line_pix),
        .clear_pix (clear_pix),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_colour (rd_colour)
    );

endmodule

/* tb_gfx_top.sv */
`timescale 1ns/100ps
`include "gfx_defines.svh"

module tb_gfx_top;

    localparam int          MAX_RECORDS       = 64;
    localparam int          CYCLES_PER_RECORD = 20000;
    localparam logic [31:0] LFSR_SEED         = 32'h03859131;

    logic            clk;
    logic            rst_n;
    wb_pkg::wb_req_t wb_req;
    wb_pkg::wb_rsp_t wb_rsp;

    logic [47:0]     patterns [MAX_RECORDS];
    logic [31:0]     lfsr;
    int              n_records;
    int              errors;
    int              checks;
    int              cycle_count;
    int              cycle_limit;

    gfx_top u_gfx_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    function automatic logic lfsr_step();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (lsb ? 32'h80200003 : 32'h0);  // taps 32, 22, 2, 1.
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // one classic cycle with the strobe held past ack.
    task automatic bus_cycle(input logic we, input wb_pkg::wb_adr_t adr,
                             input wb_pkg::wb_dat_t wdat, output wb_pkg::wb_dat_t rdat);
        int gap;
        int hold;
        int acks;
        gap  = rand_bits(2);
        hold = rand_bits(3);
        acks = 0;
        repeat (gap) @(posedge clk);
        wb_req.cyc   <= 1'b1;
        wb_req.stb   <= 1'b1;
        wb_req.we    <= we;
        wb_req.adr   <= adr;
        wb_req.dat_w <= wdat;
        @(posedge clk);
        while (!wb_rsp.ack)
            @(posedge clk);
        acks++;
        rdat = wb_rsp.dat_r;
        repeat (hold) begin
            @(posedge clk);
            if (wb_rsp.ack)
                acks++;                              // stalled host, strobe still up.
        end
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
        @(posedge clk);
        if (wb_rsp.ack)
            acks++;                                  // second ack for one strobe.
        check_value($sformatf("ack count at address %0d", adr), 1, acks);
    endtask

    task automatic write_reg(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat);
        wb_pkg::wb_dat_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t dat);
        bus_cycle(1'b0, adr, 16'h0000, dat);
    endtask

    task automatic wait_done(input string name);
        wb_pkg::wb_dat_t st;
        st = '0;
        while (!st[1]) begin
            read_reg(`GFX_REG_STATUS, st);
            check_value({name, " busy flag"}, int'(!st[1]), int'(st[0]));
        end
    endtask

    task automatic load_line(input gfx_pkg::x_coord_t x0, input gfx_pkg::y_coord_t y0,
                             input gfx_pkg::x_coord_t x1, input gfx_pkg::y_coord_t y1,
                             input gfx_pkg::colour_t col);
        write_reg(`GFX_REG_P0, {1'b0, y0, x0});
        write_reg(`GFX_REG_P1, {1'b0, y1, x1});
        write_reg(`GFX_REG_COLOUR, {13'd0, col});
    endtask

    task automatic probe_pixel(input gfx_pkg::x_coord_t x, input gfx_pkg::y_coord_t y,
                               input int expected);
        wb_pkg::wb_dat_t rdat;
        write_reg(`GFX_REG_PIX_ADR, {1'b0, y, x});
        read_reg(`GFX_REG_PIX_DAT, rdat);
        check_value($sformatf("pixel (%0d,%0d)", x, y), expected, int'(rdat));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // records
    task automatic run_record(input int idx, input logic [47:0] rec);
        logic [3:0]        op;
        gfx_pkg::x_coord_t x0;
        gfx_pkg::y_coord_t y0;
        gfx_pkg::x_coord_t x1;
        gfx_pkg::y_coord_t y1;
        gfx_pkg::colour_t  col;
        logic [7:0]        expv;
        wb_pkg::wb_dat_t   rdat;
        op   = rec[47:44];
        x0   = rec[43:36];
        y0   = rec[34:28];
        x1   = rec[27:20];
        y1   = rec[18:12];
        col  = rec[10:8];
        expv = rec[7:0];
        case (op)
            4'h0: begin
                read_reg(`GFX_REG_STATUS, rdat);
                check_value($sformatf("status, record %0d", idx), int'(expv), int'(rdat));
            end
            4'h1: begin
                write_reg(`GFX_REG_COLOUR, {13'd0, col});
                write_reg(`GFX_REG_CTRL, 16'h0002);
                wait_done("clear");
            end
            4'h2: begin
                load_line(x0, y0, x1, y1, col);
                write_reg(`GFX_REG_CTRL, 16'h0001);
                wait_done("line");
            end
            4'h3: probe_pixel(x0, y0, int'(expv));
            4'h4: begin
                load_line(x0, y0, x1, y1, col);
                write_reg(`GFX_REG_CTRL, 16'h0001);
                write_reg(`GFX_REG_CTRL, 16'h0002);      // lands while the line runs.
                read_reg(`GFX_REG_STATUS, rdat);
                check_value("status after clear request", int'(expv), int'(rdat));
                wait_done("line with clear request");
            end
            4'h5: begin
                load_line(x0, y0, x1, y1, col);
                read_reg(`GFX_REG_P0, rdat);
                check_value("P0 readback", int'({1'b0, y0, x0}), int'(rdat));
                read_reg(`GFX_REG_P1, rdat);
                check_value("P1 readback", int'({1'b0, y1, x1}), int'(rdat));
                read_reg(`GFX_REG_COLOUR, rdat);
                check_value("COLOUR readback", int'(col), int'(rdat));
            end
            default: begin
                errors++;
                $display("record %0d has an unknown opcode %0h", idx, op);
            end
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    initial begin
        wb_req = '0;
        rst_n  = 1'b0;
        lfsr   = LFSR_SEED;
        errors = 0;
        checks = 0;
        foreach (patterns[i])
            patterns[i] = '1;
        $readmemh("gfx_patterns.txt", patterns);
        n_records = 0;
        while (n_records < MAX_RECORDS && patterns[n_records][47:44] != 4'hf)
            n_records++;
        cycle_limit = n_records * CYCLES_PER_RECORD + 1000;
        if (n_records == 0) begin
            errors++;
            $display("no records were loaded from gfx_patterns.txt");
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_records; i++)
            run_record(i, patterns[i]);
        $display("errors: %0d, checks: %0d, records: %0d", errors, checks, n_records);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // stops a hung run.
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
gfx_pkg.sv
wb_pkg.sv
gfx_wb_regs.sv
drawline.sv
clear_screen.sv
framebuffer.sv
gfx_top.sv
tb_gfx_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gfx_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PATTERNS  ?= gfx_patterns.txt
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(PATTERNS)
	./$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* gfx_patterns.txt */
// columns: op_x0_y0_x1_y1_colour_expected, hex; op 0 status, 1 clear, 2 line,
// 3 probe at x0 y0, 4 line with a clear request while busy, 5 register readback, f end
0_00_00_00_00_0_00
1_00_00_00_00_5_00
0_00_00_00_00_0_02
3_00_00_00_00_0_05
3_9f_00_00_00_0_05
3_00_77_00_00_0_05
3_9f_77_00_00_0_05
3_50_3c_00_00_0_05
// horizontal (10,20) to (40,20), colour 2
2_0a_14_28_14_2_00
3_0a_14_00_00_0_02
3_19_14_00_00_0_02
3_28_14_00_00_0_02
3_29_14_00_00_0_05
3_19_15_00_00_0_05
// vertical (100,5) to (100,50), colour 3
2_64_05_64_32_3_00
3_64_05_00_00_0_03
3_64_1e_00_00_0_03
3_64_32_00_00_0_03
3_64_33_00_00_0_05
3_65_1e_00_00_0_05
// diagonal (20,60) to (50,90), colour 6
2_14_3c_32_5a_6_00
3_14_3c_00_00_0_06
3_23_4b_00_00_0_06
3_32_5a_00_00_0_06
3_24_4b_00_00_0_05
3_23_4c_00_00_0_05
// steep, right to left and upward, (130,100) to (120,70), colour 4
2_82_64_78_46_4_00
3_82_64_00_00_0_04
3_81_62_00_00_0_04
3_7d_55_00_00_0_04
3_78_46_00_00_0_04
3_81_64_00_00_0_05
3_7e_55_00_00_0_05
// off the right edge, (150,10) to (200,10), colour 7
2_96_0a_c8_0a_7_00
0_00_00_00_00_0_02
3_96_0a_00_00_0_07
3_9f_0a_00_00_0_07
3_95_0a_00_00_0_05
3_9f_0b_00_00_0_05
// clear request while (0,110) to (60,110) colour 1 is drawn
4_00_6e_3c_6e_1_01
3_00_6e_00_00_0_01
3_3c_6e_00_00_0_01
3_3d_6e_00_00_0_05
3_1e_6f_00_00_0_05
3_50_3c_00_00_0_05
// register readback, (77,33) to (3,119), colour 6
5_4d_21_03_77_6_00
f_00_00_00_00_0_00
